// File: compile.f
+incdir+common
common/tlb_pkg.sv
common/tlb_search_if.sv
tlb/tlb_entry.sv
tlb/tlb_hit_merge.sv
tlb/tlb_top.sv
verification/tlb_checker.sv
verification/tlb_tb.sv

// File: Bender.yml
package:
  name: tlb

sources:
  - include_dirs:
      - common
    files:
      - common/tlb_pkg.sv
      - common/tlb_search_if.sv
      - tlb/tlb_entry.sv
      - tlb/tlb_hit_merge.sv
      - tlb/tlb_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verification/tlb_checker.sv
      - verification/tlb_tb.sv

// File: verification/tlb_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_tb;

    localparam int TIMEOUT = 100;
    // bit 18 clear, so it never matches a written entry
    localparam tlb_pkg::vpn2_t IDLE_VPN2 = 19'h00001;

    logic                   clk;
    logic                   rst_n;
    tlb_pkg::vpn2_t         s0_vpn2;
    tlb_pkg::asid_t         s0_asid;
    logic                   s0_odd_page;
    tlb_pkg::vpn2_t         s1_vpn2;
    tlb_pkg::asid_t         s1_asid;
    logic                   s1_odd_page;
    logic                   s0_found;
    tlb_pkg::tlb_index_t    s0_index;
    tlb_pkg::pfn_t          s0_pfn;
    tlb_pkg::cache_attr_t   s0_c;
    logic                   s0_d;
    logic                   s0_v;
    logic                   s1_found;
    tlb_pkg::tlb_index_t    s1_index;
    tlb_pkg::pfn_t          s1_pfn;
    tlb_pkg::cache_attr_t   s1_c;
    logic                   s1_d;
    logic                   s1_v;
    logic                   we;
    tlb_pkg::tlb_index_t    w_index;
    tlb_pkg::vpn2_t         w_vpn2;
    tlb_pkg::asid_t         w_asid;
    logic                   w_g;
    tlb_pkg::page_pair_t    w_pair;

    // reference model of the entries
    tlb_pkg::vpn2_t         m_vpn2 [`TLB_ENTRIES];
    tlb_pkg::asid_t         m_asid [`TLB_ENTRIES];
    logic                   m_g [`TLB_ENTRIES];
    tlb_pkg::page_pair_t    m_pages [`TLB_ENTRIES];

    logic [31:0]            rng = 32'h52ba;
    logic                   check_en = 1'b0;
    int                     checks_done = 0;
    int                     checks = 0;
    int                     errors = 0;
    int                     test_start = 0;

    tlb_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .s0_vpn2     (s0_vpn2),
        .s0_odd_page (s0_odd_page),
        .s0_asid     (s0_asid),
        .s0_found    (s0_found),
        .s0_index    (s0_index),
        .s0_pfn      (s0_pfn),
        .s0_c        (s0_c),
        .s0_d        (s0_d),
        .s0_v        (s0_v),
        .s1_vpn2     (s1_vpn2),
        .s1_odd_page (s1_odd_page),
        .s1_asid     (s1_asid),
        .s1_found    (s1_found),
        .s1_index    (s1_index),
        .s1_pfn      (s1_pfn),
        .s1_c        (s1_c),
        .s1_d        (s1_d),
        .s1_v        (s1_v),
        .we          (we),
        .w_index     (w_index),
        .w_vpn2      (w_vpn2),
        .w_asid      (w_asid),
        .w_g         (w_g),
        .w_pfn0      (w_pair.page0.pfn),
        .w_c0        (w_pair.page0.c),
        .w_d0        (w_pair.page0.d),
        .w_v0        (w_pair.page0.v),
        .w_pfn1      (w_pair.page1.pfn),
        .w_c1        (w_pair.page1.c),
        .w_d1        (w_pair.page1.d),
        .w_v1        (w_pair.page1.v)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // vpn2 match, and asid match unless the entry is global
    function automatic void lookup(input tlb_pkg::vpn2_t vpn2, input tlb_pkg::asid_t asid,
                                   input logic odd, output logic found,
                                   output tlb_pkg::tlb_index_t index,
                                   output tlb_pkg::page_t page);
        tlb_pkg::page_pair_t pair;
        found = 1'b0;
        index = '0;
        pair = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (m_vpn2[i] == vpn2 && (m_g[i] || m_asid[i] == asid)) begin
                found = 1'b1;
                index = tlb_pkg::tlb_index_t'(i);
                pair = m_pages[i];
            end
        end
        page = odd ? pair.page1 : pair.page0;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_port(input string port, input tlb_pkg::vpn2_t vpn2,
                              input tlb_pkg::asid_t asid, input logic odd,
                              input logic found, input tlb_pkg::tlb_index_t index,
                              input tlb_pkg::pfn_t pfn, input tlb_pkg::cache_attr_t c,
                              input logic d, input logic v);
        logic                e_found;
        tlb_pkg::tlb_index_t e_index;
        tlb_pkg::page_t      e_page;
        lookup(vpn2, asid, odd, e_found, e_index, e_page);
        compare_field({port, "_found"}, found, e_found);
        compare_field({port, "_index"}, index, e_index);
        compare_field({port, "_pfn"}, pfn, e_page.pfn);
        compare_field({port, "_c"}, c, e_page.c);
        compare_field({port, "_d"}, d, e_page.d);
        compare_field({port, "_v"}, v, e_page.v);
    endtask

    // outputs are combinational, so they are settled at the falling edge
    always @(negedge clk) begin
        if (check_en) begin
            check_port("s0", s0_vpn2, s0_asid, s0_odd_page,
                       s0_found, s0_index, s0_pfn, s0_c, s0_d, s0_v);
            check_port("s1", s1_vpn2, s1_asid, s1_odd_page,
                       s1_found, s1_index, s1_pfn, s1_c, s1_d, s1_v);
            checks_done <= checks_done + 1;
        end
    end

    task automatic random_pair(output tlb_pkg::page_pair_t pair);
        rng = xorshift(rng);
        pair.page0 = rng[24:0];
        rng = xorshift(rng);
        pair.page1 = rng[24:0];
    endtask

    task automatic write_entry(input tlb_pkg::tlb_index_t idx, input tlb_pkg::vpn2_t vpn2,
                               input tlb_pkg::asid_t asid, input logic g,
                               input tlb_pkg::page_pair_t pair);
        @(posedge clk);
        we <= 1'b1;
        w_index <= idx;
        w_vpn2 <= vpn2;
        w_asid <= asid;
        w_g <= g;
        w_pair <= pair;
        @(posedge clk);
        we <= 1'b0;
        // the dut stores on this edge
        m_vpn2[idx] = vpn2;
        m_asid[idx] = asid;
        m_g[idx] = g;
        m_pages[idx] = pair;
    endtask

    task automatic search(input tlb_pkg::vpn2_t vpn2_0, input tlb_pkg::asid_t asid_0,
                          input logic odd_0, input tlb_pkg::vpn2_t vpn2_1,
                          input tlb_pkg::asid_t asid_1, input logic odd_1);
        @(posedge clk);
        s0_vpn2 <= vpn2_0;
        s0_asid <= asid_0;
        s0_odd_page <= odd_0;
        s1_vpn2 <= vpn2_1;
        s1_asid <= asid_1;
        s1_odd_page <= odd_1;
    endtask

    task automatic wait_checks(input int n);
        int target;
        int cycles;
        target = checks_done + n;
        cycles = 0;
        while (checks_done < target && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (checks_done < target) begin
            $display("timeout: compare process made no progress");
            $display("Done: errors found");
            $finish;
        end
    endtask

    task automatic end_test(input string name);
        wait_checks(2);
        $display("%s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        tlb_pkg::page_pair_t pair;
        tlb_pkg::vpn2_t      old_vpn2;
        tlb_pkg::vpn2_t      new_vpn2;
        tlb_pkg::tlb_index_t idx;
        tlb_pkg::tlb_index_t a;
        tlb_pkg::tlb_index_t b;
        rst_n = 1'b0;
        we = 1'b0;
        w_index = '0;
        w_vpn2 = '0;
        w_asid = '0;
        w_g = 1'b0;
        w_pair = '0;
        s0_vpn2 = IDLE_VPN2;
        s0_asid = '0;
        s0_odd_page = 1'b0;
        s1_vpn2 = IDLE_VPN2;
        s1_asid = '0;
        s1_odd_page = 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            m_vpn2[i] = '0;
            m_asid[i] = '0;
            m_g[i] = 1'b0;
            m_pages[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_en <= 1'b1;

        // low nibble of vpn2 is the index, which keeps vpn2 unique
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            random_pair(pair);
            rng = xorshift(rng);
            idx = tlb_pkg::tlb_index_t'(i);
            write_entry(idx, {1'b1, rng[13:0], idx}, rng[21:14], (i % 4 == 0), pair);
        end
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            search(m_vpn2[i], m_asid[i], 1'b0, m_vpn2[i], m_asid[i], 1'b1);
            search(m_vpn2[i], m_asid[i], 1'b1, m_vpn2[i], m_asid[i], 1'b0);
        end
        end_test("fill and search");

        // entry 0 is global, entry 1 is not
        search(m_vpn2[0], ~m_asid[0], 1'b0, m_vpn2[1], ~m_asid[1], 1'b1);
        end_test("global bit");

        search(19'h00010, 8'h00, 1'b0, 19'h0abcd, 8'h5a, 1'b1);
        end_test("miss");

        old_vpn2 = m_vpn2[5];
        new_vpn2 = {1'b1, ~old_vpn2[17:4], 4'd5};
        random_pair(pair);
        // search held across the write, so the cycle after the store edge is seen
        search(new_vpn2, m_asid[5], 1'b0, old_vpn2, m_asid[5], 1'b1);
        write_entry(4'd5, new_vpn2, m_asid[5], 1'b0, pair);
        end_test("overwrite");

        for (int n = 0; n < 200; n++) begin
            rng = xorshift(rng);
            if (rng[1:0] == 2'b00) begin
                idx = rng[5:2];
                random_pair(pair);
                rng = xorshift(rng);
                write_entry(idx, {1'b1, rng[13:0], idx}, rng[21:14], rng[22], pair);
            end else begin
                a = rng[5:2];
                b = rng[19:16];
                search(m_vpn2[a], rng[6] ? m_asid[a] : rng[15:8], rng[7],
                       rng[20] ? 19'h00020 : m_vpn2[b], m_asid[b], rng[21]);
            end
        end
        end_test("random");

        // failed bound assertions
        errors = errors + i_dut.i_checker.failures;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tlb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_checker (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  tlb_pkg::vpn2_t       s0_vpn2,
    input  tlb_pkg::asid_t       s0_asid,
    input  wire logic            s0_odd_page,
    input  wire logic            s0_found,
    input  tlb_pkg::tlb_index_t  s0_index,
    input  tlb_pkg::pfn_t        s0_pfn,
    input  tlb_pkg::cache_attr_t s0_c,
    input  wire logic            s0_d,
    input  wire logic            s0_v,
    input  tlb_pkg::vpn2_t       s1_vpn2,
    input  tlb_pkg::asid_t       s1_asid,
    input  wire logic            s1_odd_page,
    input  wire logic            s1_found,
    input  tlb_pkg::tlb_index_t  s1_index,
    input  tlb_pkg::pfn_t        s1_pfn,
    input  tlb_pkg::cache_attr_t s1_c,
    input  wire logic            s1_d,
    input  wire logic            s1_v
);

    int failures = 0;

    // a miss leaves every page field at zero
    a_s0_miss_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !s0_found |-> ({s0_pfn, s0_c, s0_d, s0_v} == '0))
        else begin
            $error("s0 page fields not zero on a miss");
            failures++;
        end

    a_s1_miss_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !s1_found |-> ({s1_pfn, s1_c, s1_d, s1_v} == '0))
        else begin
            $error("s1 page fields not zero on a miss");
            failures++;
        end

    // same request on both ports, same answer
    a_ports_agree: assert property (@(posedge clk) disable iff (!rst_n)
        ({s0_vpn2, s0_asid, s0_odd_page} == {s1_vpn2, s1_asid, s1_odd_page}) |->
        ({s0_found, s0_index, s0_pfn, s0_c, s0_d, s0_v} ==
         {s1_found, s1_index, s1_pfn, s1_c, s1_d, s1_v}))
        else begin
            $error("search ports disagree on equal requests");
            failures++;
        end

endmodule

bind tlb_top tlb_checker i_checker (.*);

`default_nettype wire

// File: tlb/tlb_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_top (
    input  wire logic                clk,
    input  wire logic                rst_n,

    // search port 0
    input  tlb_pkg::vpn2_t           s0_vpn2,
    input  wire logic                s0_odd_page,
    input  tlb_pkg::asid_t           s0_asid,
    output logic                     s0_found,
    output tlb_pkg::tlb_index_t      s0_index,
    output tlb_pkg::pfn_t            s0_pfn,
    output tlb_pkg::cache_attr_t     s0_c,
    output logic                     s0_d,
    output logic                     s0_v,

    // search port 1
    input  tlb_pkg::vpn2_t           s1_vpn2,
    input  wire logic                s1_odd_page,
    input  tlb_pkg::asid_t           s1_asid,
    output logic                     s1_found,
    output tlb_pkg::tlb_index_t      s1_index,
    output tlb_pkg::pfn_t            s1_pfn,
    output tlb_pkg::cache_attr_t     s1_c,
    output logic                     s1_d,
    output logic                     s1_v,

    // write port
    input  wire logic                we,
    input  tlb_pkg::tlb_index_t      w_index,
    input  tlb_pkg::vpn2_t           w_vpn2,
    input  tlb_pkg::asid_t           w_asid,
    input  wire logic                w_g,
    input  tlb_pkg::pfn_t            w_pfn0,
    input  tlb_pkg::cache_attr_t     w_c0,
    input  wire logic                w_d0,
    input  wire logic                w_v0,
    input  tlb_pkg::pfn_t            w_pfn1,
    input  tlb_pkg::cache_attr_t     w_c1,
    input  wire logic                w_d1,
    input  wire logic                w_v1
);

    tlb_search_if s0_if ();
    tlb_search_if s1_if ();

    tlb_pkg::page_pair_t w_pages;
    tlb_pkg::page_pair_t entry_pages [`TLB_ENTRIES];
    tlb_pkg::page_t      s0_page;
    tlb_pkg::page_t      s1_page;

    assign s0_if.vpn2     = s0_vpn2;
    assign s0_if.asid     = s0_asid;
    assign s0_if.odd_page = s0_odd_page;

    assign s1_if.vpn2     = s1_vpn2;
    assign s1_if.asid     = s1_asid;
    assign s1_if.odd_page = s1_odd_page;

    // write data as one page pair
    assign w_pages.page0 = '{pfn: w_pfn0, c: w_c0, d: w_d0, v: w_v0};
    assign w_pages.page1 = '{pfn: w_pfn1, c: w_c1, d: w_d1, v: w_v1};

    for (genvar g = 0; g < `TLB_ENTRIES; g++) begin : gen_entry
        tlb_entry #(
            .ENTRY_ID (g)
        ) i_entry (
            .clk     (clk),
            .rst_n   (rst_n),
            .we      (we),
            .w_index (w_index),
            .w_vpn2  (w_vpn2),
            .w_asid  (w_asid),
            .w_g     (w_g),
            .w_pages (w_pages),
            .s0      (s0_if),
            .s1      (s1_if),
            .hit0    (s0_if.hits[g]),
            .hit1    (s1_if.hits[g]),
            .pages   (entry_pages[g])
        );
    end

    tlb_hit_merge i_merge0 (
        .sif   (s0_if),
        .pages (entry_pages),
        .found (s0_found),
        .index (s0_index),
        .page  (s0_page)
    );

    tlb_hit_merge i_merge1 (
        .sif   (s1_if),
        .pages (entry_pages),
        .found (s1_found),
        .index (s1_index),
        .page  (s1_page)
    );

    assign s0_pfn = s0_page.pfn;
    assign s0_c   = s0_page.c;
    assign s0_d   = s0_page.d;
    assign s0_v   = s0_page.v;

    assign s1_pfn = s1_page.pfn;
    assign s1_c   = s1_page.c;
    assign s1_d   = s1_page.d;
    assign s1_v   = s1_page.v;

endmodule

`default_nettype wire

// File: tlb/tlb_hit_merge.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_hit_merge (
    tlb_search_if.merge          sif,
    input  tlb_pkg::page_pair_t  pages [`TLB_ENTRIES],
    output logic                 found,
    output tlb_pkg::tlb_index_t  index,
    output tlb_pkg::page_t       page
);

    tlb_pkg::tlb_index_t index_acc;
    tlb_pkg::page_pair_t pair_acc;

    // at most one hit expected, so an OR over the entries acts as a mux
    always_comb begin
        index_acc = '0;
        pair_acc  = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (sif.hits[i]) begin
                index_acc = index_acc | tlb_pkg::tlb_index_t'(i);
                pair_acc  = pair_acc | pages[i];
            end
        end
    end

    assign found = |sif.hits;
    assign index = index_acc;

    // odd page bit picks the half of the pair
    always_comb begin
        if (sif.odd_page) begin
            page = pair_acc.page1;
        end else begin
            page = pair_acc.page0;
        end
    end

endmodule

`default_nettype wire

// File: tlb/tlb_entry.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_entry #(
    parameter int unsigned ENTRY_ID = 0
) (
    input  wire logic                clk,
    input  wire logic                rst_n,

    // indexed write
    input  wire logic                we,
    input  tlb_pkg::tlb_index_t      w_index,
    input  tlb_pkg::vpn2_t           w_vpn2,
    input  tlb_pkg::asid_t           w_asid,
    input  wire logic                w_g,
    input  tlb_pkg::page_pair_t      w_pages,

    // search ports
    tlb_search_if.compare            s0,
    tlb_search_if.compare            s1,
    output logic                     hit0,
    output logic                     hit1,
    output tlb_pkg::page_pair_t      pages
);

    tlb_pkg::vpn2_t      vpn2_q;
    tlb_pkg::asid_t      asid_q;
    logic                g_q;
    tlb_pkg::page_pair_t pages_q;
    logic                sel;

    // write decode, one compare per entry
    assign sel = we && (w_index == tlb_pkg::tlb_index_t'(ENTRY_ID));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vpn2_q  <= '0;
            asid_q  <= '0;
            g_q     <= 1'b0;
            pages_q <= '0;
        end else if (sel) begin
            vpn2_q  <= w_vpn2;
            asid_q  <= w_asid;
            g_q     <= w_g;
            pages_q <= w_pages;
        end
    end

    // global entries ignore the asid
    assign hit0 = (s0.vpn2 == vpn2_q) && (g_q || (s0.asid == asid_q));
    assign hit1 = (s1.vpn2 == vpn2_q) && (g_q || (s1.asid == asid_q));

    assign pages = pages_q;

endmodule

`default_nettype wire

// File: common/tlb_search_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "tlb_defines.svh"

interface tlb_search_if;

    tlb_pkg::vpn2_t             vpn2;
    tlb_pkg::asid_t             asid;
    logic                       odd_page;
    // one bit per entry
    logic [`TLB_ENTRIES-1:0]    hits;

    modport compare (input vpn2, input asid);
    modport merge (input hits, input odd_page);

endinterface

`default_nettype wire

// File: common/tlb_pkg.sv
`default_nettype none

`include "tlb_defines.svh"

package tlb_pkg;

    typedef logic [`TLB_VPN2_W-1:0] vpn2_t;
    typedef logic [`TLB_ASID_W-1:0] asid_t;
    typedef logic [`TLB_PFN_W-1:0] pfn_t;
    typedef logic [`TLB_CACHE_W-1:0] cache_attr_t;
    typedef logic [`TLB_INDEX_W-1:0] tlb_index_t;

    // translation for one page of the pair
    typedef struct packed {
        pfn_t        pfn;
        cache_attr_t c;
        logic        d;
        logic        v;
    } page_t;

    // even page in page0, odd page in page1
    typedef struct packed {
        page_t page0;
        page_t page1;
    } page_pair_t;

endpackage

`default_nettype wire

// File: common/tlb_defines.svh
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// tlb geometry
`define TLB_ENTRIES 16
`define TLB_INDEX_W 4

// entryhi fields
`define TLB_VPN2_W 19
`define TLB_ASID_W 8

// entrylo fields
`define TLB_PFN_W 20
`define TLB_CACHE_W 3

`endif
